// File: source/sram_defines.svh
`ifndef SRAM_DEFINES_SVH
`define SRAM_DEFINES_SVH

// width of one data word
`define SRAM_DATA_W 32

// wishbone word address width, covers all banks
`define SRAM_ADDR_W 10

// bank count and the width of the bank index
`define SRAM_NUM_BANKS 4
`define SRAM_BANK_SEL_W 2

// words held by each bank
`define SRAM_BANK_DEPTH 256
`define SRAM_BANK_ADDR_W (`SRAM_ADDR_W - `SRAM_BANK_SEL_W)

// 1 builds each bank from the two-port array plus an output register,
// 0 infers a single-port array
`define SRAM_SUBST_1R1W 1

// request to valid bank output, in cycles
`define SRAM_RD_LAT (`SRAM_SUBST_1R1W + 1)

`endif

// File: source/sram_pkg.sv
`include "sram_defines.svh"

package sram_pkg;

   // one data word as stored and returned on the bus
   typedef logic [`SRAM_DATA_W-1:0] word_t;

   // wishbone word address, bank index in the low bits
   typedef logic [`SRAM_ADDR_W-1:0] wb_addr_t;

   // address inside one bank
   typedef logic [`SRAM_BANK_ADDR_W-1:0] bank_addr_t;

   // bank index
   typedef logic [`SRAM_BANK_SEL_W-1:0] bank_sel_t;

   // front end FSM
   //   IDLE  waits for cyc and stb
   //   WAIT  counts the bank latency
   //   ACK   one cycle of ack
   typedef enum logic [1:0]
   {
      IDLE,
      WAIT,
      ACK
   } front_state_t;

endpackage

// File: source/mem_1r1w.sv
`timescale 1ns/100ps
`include "sram_defines.svh"

module mem_1r1w
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 w_v_i,
   input  sram_pkg::bank_addr_t w_addr_i,
   input  sram_pkg::word_t      w_data_i,
   input  logic                 r_v_i,
   input  sram_pkg::bank_addr_t r_addr_i,
   output sram_pkg::word_t      r_data_o
);

   // storage, contents are not cleared by reset
   sram_pkg::word_t mem [`SRAM_BANK_DEPTH];

   // write port
   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // read port, the word is held until the next read
   // same address on both ports in one cycle gives no defined result
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         r_data_o <= '0;
      end
      else
      begin
         if (r_v_i)
         begin
            r_data_o <= mem[r_addr_i];
         end
      end
   end

endmodule

// File: source/mem_1rw_sync.sv
`timescale 1ns/100ps
`include "sram_defines.svh"

module mem_1rw_sync
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 v_i,
   input  logic                 w_i,
   input  sram_pkg::bank_addr_t addr_i,
   input  sram_pkg::word_t      data_i,
   output sram_pkg::word_t      data_o
);

   if (`SRAM_SUBST_1R1W)
   begin : g_subst
      sram_pkg::word_t r_data;

      // one request goes to exactly one of the two ports
      mem_1r1w u_mem
      (
         .clk_i    (clk_i),
         .rst_n_i  (rst_n_i),
         .w_v_i    (v_i & w_i),
         .w_addr_i (addr_i),
         .w_data_i (data_i),
         .r_v_i    (v_i & ~w_i),
         .r_addr_i (addr_i),
         .r_data_o (r_data)
      );

      // extra stage after the array read, two cycles in total
      always_ff @(posedge clk_i or negedge rst_n_i)
      begin
         if (!rst_n_i)
         begin
            data_o <= '0;
         end
         else
         begin
            data_o <= r_data;
         end
      end
   end
   else
   begin : g_infer
      sram_pkg::word_t mem [`SRAM_BANK_DEPTH];

      always_ff @(posedge clk_i)
      begin
         if (v_i && w_i)
         begin
            mem[addr_i] <= data_i;
         end
      end

      // registered read, one cycle, output holds between reads
      always_ff @(posedge clk_i or negedge rst_n_i)
      begin
         if (!rst_n_i)
         begin
            data_o <= '0;
         end
         else
         begin
            if (v_i && !w_i)
            begin
               data_o <= mem[addr_i];
            end
         end
      end
   end

endmodule

// File: source/wb_bank_front.sv
`timescale 1ns/100ps
`include "sram_defines.svh"

module wb_bank_front
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  sram_pkg::wb_addr_t         wb_adr_i,
   input  sram_pkg::word_t            wb_dat_i,
   output logic                       wb_ack_o,
   output logic [`SRAM_NUM_BANKS-1:0] bank_v_o,
   output logic                       bank_w_o,
   output sram_pkg::bank_addr_t       bank_addr_o,
   output sram_pkg::word_t            bank_data_o,
   output logic                       rd_start_o,
   output sram_pkg::bank_sel_t        rd_bank_o
);

   localparam int CNT_W = $clog2(`SRAM_RD_LAT + 1);
   localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`SRAM_RD_LAT - 1);

   sram_pkg::front_state_t     state_q;
   logic [CNT_W-1:0]           lat_cnt_q;
   logic                       req;
   logic                       accept;
   sram_pkg::bank_sel_t        req_bank;
   sram_pkg::bank_addr_t       req_addr;
   logic [`SRAM_NUM_BANKS-1:0] req_onehot;

   assign req = wb_cyc_i & wb_stb_i;

   // only taken in IDLE, the master holds it through WAIT and ACK
   assign accept = (state_q == sram_pkg::IDLE) && req;

   // low address bits pick the bank, the rest address the word inside it
   assign req_bank = wb_adr_i[`SRAM_BANK_SEL_W-1:0];
   assign req_addr = wb_adr_i[`SRAM_ADDR_W-1:`SRAM_BANK_SEL_W];

   always_comb
   begin
      for (int b = 0; b < `SRAM_NUM_BANKS; b++)
      begin
         req_onehot[b] = (req_bank == b);
      end
   end

   // request fields, qualified by bank_v_o downstream
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         bank_w_o    <= wb_we_i;
         bank_addr_o <= req_addr;
         bank_data_o <= wb_dat_i;
         rd_bank_o   <= req_bank;
      end
   end

   // writes wait as long as reads so every access acks at the same point
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q    <= sram_pkg::IDLE;
         lat_cnt_q  <= '0;
         bank_v_o   <= '0;
         rd_start_o <= 1'b0;
         wb_ack_o   <= 1'b0;
      end
      else
      begin
         // strobes are single cycle
         bank_v_o   <= '0;
         rd_start_o <= 1'b0;
         wb_ack_o   <= 1'b0;
         case (state_q)
            sram_pkg::IDLE:
            begin
               if (req)
               begin
                  bank_v_o   <= req_onehot;
                  rd_start_o <= ~wb_we_i;
                  lat_cnt_q  <= CNT_LOAD;
                  state_q    <= sram_pkg::WAIT;
               end
            end
            sram_pkg::WAIT:
            begin
               if (lat_cnt_q == '0)
               begin
                  wb_ack_o <= 1'b1;
                  state_q  <= sram_pkg::ACK;
               end
               else
               begin
                  lat_cnt_q <= lat_cnt_q - 1'b1;
               end
            end
            default:
            begin
               // ack is up this cycle, back to IDLE for the next request
               state_q <= sram_pkg::IDLE;
            end
         endcase
      end
   end

endmodule

// File: source/bank_read_mux.sv
`timescale 1ns/100ps
`include "sram_defines.svh"

module bank_read_mux
(
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  rd_start_i,
   input  sram_pkg::bank_sel_t                   rd_bank_i,
   input  sram_pkg::word_t [`SRAM_NUM_BANKS-1:0] bank_data_i,
   output sram_pkg::word_t                       wb_dat_o
);

   localparam int RD_LAT = `SRAM_RD_LAT;

   // bank index travelling alongside the read in flight
   sram_pkg::bank_sel_t sel_q [RD_LAT];

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int s = 0; s < RD_LAT; s++)
         begin
            sel_q[s] <= '0;
         end
      end
      else
      begin
         // first stage loads only when a read starts
         if (rd_start_i)
         begin
            sel_q[0] <= rd_bank_i;
         end
         for (int s = 1; s < RD_LAT; s++)
         begin
            sel_q[s] <= sel_q[s-1];
         end
      end
   end

   // last stage lines up with the bank output and the ack cycle
   assign wb_dat_o = bank_data_i[sel_q[RD_LAT-1]];

endmodule

// File: source/banked_sram_top.sv
`timescale 1ns/100ps
`include "sram_defines.svh"

module banked_sram_top
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   input  logic               wb_we_i,
   input  sram_pkg::wb_addr_t wb_adr_i,
   input  sram_pkg::word_t    wb_dat_i,
   output sram_pkg::word_t    wb_dat_o,
   output logic               wb_ack_o
);

   // front end to banks
   logic [`SRAM_NUM_BANKS-1:0] bank_v;
   logic                       bank_w;
   sram_pkg::bank_addr_t       bank_addr;
   sram_pkg::word_t            bank_wdata;

   // banks and front end to collector
   sram_pkg::word_t [`SRAM_NUM_BANKS-1:0] bank_rdata;
   logic                                  rd_start;
   sram_pkg::bank_sel_t                   rd_bank;

   wb_bank_front u_front
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_ack_o    (wb_ack_o),
      .bank_v_o    (bank_v),
      .bank_w_o    (bank_w),
      .bank_addr_o (bank_addr),
      .bank_data_o (bank_wdata),
      .rd_start_o  (rd_start),
      .rd_bank_o   (rd_bank)
   );

   // address, data and write flag are shared, only v is per bank
   for (genvar b = 0; b < `SRAM_NUM_BANKS; b++)
   begin : g_bank
      mem_1rw_sync u_bank
      (
         .clk_i   (clk_i),
         .rst_n_i (rst_n_i),
         .v_i     (bank_v[b]),
         .w_i     (bank_w),
         .addr_i  (bank_addr),
         .data_i  (bank_wdata),
         .data_o  (bank_rdata[b])
      );
   end

   bank_read_mux u_collect
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .rd_start_i  (rd_start),
      .rd_bank_i   (rd_bank),
      .bank_data_i (bank_rdata),
      .wb_dat_o    (wb_dat_o)
   );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
#(
   parameter real PERIOD_NS    = 4.0,
   parameter int  RESET_CYCLES = 5
)
(
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #(PERIOD_NS / 2.0) clk_o = ~clk_o;
      end
   end

   // reset low from time zero, released on a rising edge
   initial
   begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// File: tests/tb_checker.sv
`timescale 1ns/100ps
`include "sram_defines.svh"

module tb_checker
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   input  logic               wb_we_i,
   input  sram_pkg::wb_addr_t wb_adr_i,
   input  sram_pkg::word_t    wb_dat_i,
   input  sram_pkg::word_t    rd_dat_i,
   input  logic               wb_ack_i,
   output int                 err_cnt_o,
   output int                 chk_cnt_o,
   output int                 ack_cnt_o
);

   // first request cycle to ack, bank latency plus the front end cycle
   localparam int ACK_LAT = `SRAM_RD_LAT + 1;
   localparam int DEPTH   = 1 << `SRAM_ADDR_W;

   sram_pkg::word_t model_mem [DEPTH];
   bit              written   [DEPTH];
   logic            in_txn = 1'b0;
   logic            ack_q  = 1'b0;
   int              since  = 0;

   initial
   begin
      err_cnt_o = 0;
      chk_cnt_o = 0;
      ack_cnt_o = 0;
      foreach (written[a])
      begin
         written[a] = 1'b0;
      end
   end

   // expected word at a bus address, known is low for a word never written
   function automatic sram_pkg::word_t ref_word(input sram_pkg::wb_addr_t adr,
                                                output bit known);
      known = written[adr];
      return model_mem[adr];
   endfunction

   // sampled on the rising edge, before the DUT and the master update
   always @(posedge clk_i)
   begin
      logic            req;
      bit              known;
      sram_pkg::word_t exp;

      if (!rst_n_i)
      begin
         in_txn = 1'b0;
         since  = 0;
         ack_q  = 1'b0;
      end
      else
      begin
         req = wb_cyc_i && wb_stb_i;
         if (req && !in_txn)
         begin
            in_txn = 1'b1;
            since  = 0;
         end
         else if (in_txn)
         begin
            since++;
         end
         if (wb_ack_i)
         begin
            ack_cnt_o++;
            if (ack_q)
            begin
               $display("ERROR: ack stayed high for a second cycle at %0t", $time);
               err_cnt_o++;
            end
            if (!req)
            begin
               $display("ERROR: ack raised while no request was presented at %0t", $time);
               err_cnt_o++;
            end
            else
            begin
               if (since != ACK_LAT)
               begin
                  $display("ERROR: ack came %0d cycles after stb rose instead of %0d at %0t",
                           since, ACK_LAT, $time);
                  err_cnt_o++;
               end
               if (wb_we_i)
               begin
                  model_mem[wb_adr_i] = wb_dat_i;
                  written[wb_adr_i]   = 1'b1;
               end
               else
               begin
                  exp = ref_word(wb_adr_i, known);
                  // a word never written has no expected value
                  if (known)
                  begin
                     chk_cnt_o++;
                     if (rd_dat_i !== exp)
                     begin
                        $display("FAILED wb_dat_o at address 0x%h: expected 0x%h, actual 0x%h",
                                 wb_adr_i, exp, rd_dat_i);
                        err_cnt_o++;
                     end
                  end
               end
            end
            in_txn = 1'b0;
         end
         else if (in_txn && since == ACK_LAT + 1)
         begin
            $display("ERROR: no ack within %0d cycles of stb rising at %0t", ACK_LAT, $time);
            err_cnt_o++;
         end
         ack_q = wb_ack_i;
      end
   end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/100ps
`include "sram_defines.svh"

module tb_top;

   localparam int RESET_CYCLES = 5;
   localparam int IDLE_CYCLES  = 20;
   // 8 + 32 + 8 + 300 bus cycles of 5 clocks each
   localparam int NUM_TXN      = 348;
   localparam int MAX_CYCLES   = NUM_TXN * 5 + RESET_CYCLES + IDLE_CYCLES + 100;

   logic               clk;
   logic               rst_n;
   logic               wb_cyc;
   logic               wb_stb;
   logic               wb_we;
   sram_pkg::wb_addr_t wb_adr;
   sram_pkg::word_t    wb_dat_w;
   sram_pkg::word_t    wb_dat_r;
   logic               wb_ack;

   int                 err_cnt;
   int                 chk_cnt;
   int                 ack_cnt;
   int                 cycle_cnt    = 0;
   int                 txn_cnt      = 0;
   int                 tests_passed = 0;
   int                 tests_failed = 0;
   int                 err_base;
   int                 chk_base;
   integer             seed         = 32'h452f4c55;
   sram_pkg::wb_addr_t written_q[$];

   tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(RESET_CYCLES)) u_clk
   (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   banked_sram_top uut
   (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w),
      .wb_dat_o (wb_dat_r),
      .wb_ack_o (wb_ack)
   );

   tb_checker u_chk
   (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .wb_cyc_i  (wb_cyc),
      .wb_stb_i  (wb_stb),
      .wb_we_i   (wb_we),
      .wb_adr_i  (wb_adr),
      .wb_dat_i  (wb_dat_w),
      .rd_dat_i  (wb_dat_r),
      .wb_ack_i  (wb_ack),
      .err_cnt_o (err_cnt),
      .chk_cnt_o (chk_cnt),
      .ack_cnt_o (ack_cnt)
   );

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("Test failed");
         $finish;
      end
   end

   // one classic cycle held until ack and then stb low for one cycle
   task automatic wb_access(input logic we, input sram_pkg::wb_addr_t adr,
                            input sram_pkg::word_t dat);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= dat;
      @(posedge clk);
      while (!wb_ack)
      begin
         @(posedge clk);
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      @(posedge clk);
      txn_cnt++;
      if (we)
      begin
         written_q.push_back(adr);
      end
   endtask

   task automatic start_test();
      err_base = err_cnt;
      chk_base = chk_cnt;
   endtask

   // chk_expect below zero means any number of read compares
   task automatic close_test(input int num, input string name, input int chk_expect,
                             input int extra_errs);
      int errs;

      errs = err_cnt - err_base + extra_errs;
      if (chk_expect >= 0 && chk_cnt - chk_base != chk_expect)
      begin
         $display("test %0d made %0d read compares, %0d were due", num,
                  chk_cnt - chk_base, chk_expect);
         errs++;
      end
      if (errs == 0)
      begin
         tests_passed++;
         $display("test %0d %s: ok", num, name);
      end
      else
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", num, name, errs);
      end
   endtask

   initial
   begin
      sram_pkg::wb_addr_t adr;
      sram_pkg::word_t    dat;
      logic [31:0]        rnd;
      int                 idle_acks;
      int                 extra;
      int                 near[6];

      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wait (rst_n === 1'b1);
      @(posedge clk);
      // no ack may appear while the bus is idle after reset
      repeat (IDLE_CYCLES) @(posedge clk);
      idle_acks = ack_cnt;

      start_test();
      for (int b = 0; b < `SRAM_NUM_BANKS; b++)
      begin
         adr = sram_pkg::wb_addr_t'(32'h2c0 + b);
         dat = $random(seed);
         wb_access(1'b1, adr, dat);
         wb_access(1'b0, adr, '0);
      end
      close_test(1, "read after write in every bank", `SRAM_NUM_BANKS, 0);

      start_test();
      for (int i = 0; i < 16; i++)
      begin
         wb_access(1'b1, sram_pkg::wb_addr_t'(i), sram_pkg::word_t'({16'hc0de, 8'(i), 8'(~i)}));
      end
      for (int i = 15; i >= 0; i--)
      begin
         wb_access(1'b0, sram_pkg::wb_addr_t'(i), '0);
      end
      close_test(2, "interleaved addresses 0 to 15", 16, 0);

      // word 5 sits in bank 1 with 1, 9 and 13 in the same bank and 4 and 6 in others
      near = '{5, 1, 9, 13, 4, 6};
      start_test();
      wb_access(1'b1, 5, 32'h1111_aaaa);
      wb_access(1'b1, 5, 32'h2222_bbbb);
      foreach (near[n])
      begin
         wb_access(1'b0, sram_pkg::wb_addr_t'(near[n]), '0);
      end
      close_test(3, "overwrite keeps neighbors", 6, 0);

      start_test();
      for (int i = 0; i < 300; i++)
      begin
         rnd = $random(seed);
         dat = $random(seed);
         adr = sram_pkg::wb_addr_t'(rnd);
         // most reads go to a word already written
         if (!rnd[31] && rnd[30:29] != 2'b00)
         begin
            adr = written_q[$unsigned($random(seed)) % written_q.size()];
         end
         wb_access(rnd[31], adr, dat);
      end
      close_test(4, "random reads and writes", -1, 0);

      // a stray ack after the last request still gets counted
      repeat (5) @(posedge clk);
      @(negedge clk);

      start_test();
      extra = 0;
      if (idle_acks != 0)
      begin
         $display("ack was raised %0d times while the bus was idle after reset", idle_acks);
         extra++;
      end
      if (ack_cnt != txn_cnt)
      begin
         $display("%0d requests were made but %0d acks were seen", txn_cnt, ack_cnt);
         extra++;
      end
      close_test(5, "one ack per request", -1, extra);

      $display("summary: %0d tests ok, %0d tests with errors, %0d read compares, %0d errors",
               tests_passed, tests_failed, chk_cnt, err_cnt);
      if (tests_failed == 0 && err_cnt == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: flist.f
+incdir+source
source/sram_pkg.sv
source/mem_1r1w.sv
source/mem_1rw_sync.sv
source/wb_bank_front.sv
source/bank_read_mux.sv
source/banked_sram_top.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_top.sv
